// ==== logic/armPkg.sv ====
// Shared types for the pipelined ARMv4 subset core
// Condition NV (4'hF) has no enum member and is decoded as a no-op
// Pipeline register structs are packed so stages can clear them with '0
package armPkg;

   typedef logic [31:0] word_t;
   typedef logic [3:0]  regAddr_t;

   typedef enum logic [3:0] {
      EQ, NE, CS, CC, MI, PL, VS, VC,
      HI, LS, GE, LT, GT, LE, AL
   } condCode_t;

   // Op field, instr[27:26]
   typedef enum logic [1:0] {
      dataProc = 2'b00,
      memory   = 2'b01,
      branch   = 2'b10
   } instrClass_t;

   typedef enum logic [1:0] {
      aluAdd, aluSub, aluAnd, aluOrr
   } aluOp_t;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flags_t;

   typedef struct packed {
      logic      regWrite;
      logic      memWrite;
      logic      memToReg;
      logic      branch;
      logic      aluSrcImm;   // B operand from imm
      logic      setFlags;
      aluOp_t    aluOp;
      condCode_t cond;
   } ctrl_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    rd1;
      word_t    rd2;
      word_t    imm;
      regAddr_t ra1;
      regAddr_t ra2;
      regAddr_t wa;
   } execReg_t;

   // Write enables here are already gated by the condition
   typedef struct packed {
      logic     regWrite;
      logic     memWrite;
      logic     memToReg;
      word_t    aluResult;
      word_t    writeData;
      regAddr_t wa;
   } memReg_t;

   typedef struct packed {
      logic     regWrite;
      logic     memToReg;
      word_t    aluResult;
      word_t    readData;
      regAddr_t wa;
   } wbReg_t;

   localparam regAddr_t r15Reg = 4'hF;

endpackage

// ==== logic/armDecoder.sv ====
// Decode for ADD/SUB/AND/ORR, LDR/STR with positive 12-bit offset and B
// Anything else, including Rd = R15 writes, becomes an unconditional no-op
// Unused read ports are pointed at R15, which is never written, so they
// never trigger forwarding or a load-use stall
`timescale 1ns/1ps

module armDecoder import armPkg::*;
(
   input  word_t    instr,
   output ctrl_t    ctrl,
   output word_t    imm,
   output regAddr_t ra1,
   output regAddr_t ra2,
   output regAddr_t wa
);

   instrClass_t cls;
   aluOp_t      dpOp;
   logic        dpOk;

   assign cls = instrClass_t'(instr[27:26]);

   // Data processing funct bits [24:21]
   always_comb
   begin
      dpOk = 1'b1;
      case (instr[24:21])
         4'b0100: dpOp = aluAdd;
         4'b0010: dpOp = aluSub;
         4'b0000: dpOp = aluAnd;
         4'b1100: dpOp = aluOrr;
         default:
         begin
            dpOp = aluAdd;
            dpOk = 1'b0;
         end
      endcase
   end

   always_comb
   begin
      ctrl      = '0;
      ctrl.cond = AL;           // No-op default
      imm       = '0;
      ra1       = r15Reg;
      ra2       = r15Reg;
      wa        = instr[15:12];
      if (instr[31:28] != 4'hF)
      begin
         case (cls)
            dataProc:
               if (dpOk && instr[15:12] != r15Reg)
               begin
                  ctrl.regWrite  = 1'b1;
                  ctrl.aluSrcImm = instr[25];
                  ctrl.setFlags  = instr[20];
                  ctrl.aluOp     = dpOp;
                  ctrl.cond      = condCode_t'(instr[31:28]);
                  ra1            = instr[19:16];
                  if (instr[25])
                     imm = {24'b0, instr[7:0]};   // Rotate field ignored
                  else
                     ra2 = instr[3:0];
               end
            memory:
               // Only P=1 U=1 B=0 W=0 with immediate offset
               if (instr[25:21] == 5'b01100 && (!instr[20] || instr[15:12] != r15Reg))
               begin
                  ctrl.regWrite  = instr[20];
                  ctrl.memToReg  = instr[20];
                  ctrl.memWrite  = ~instr[20];
                  ctrl.aluSrcImm = 1'b1;
                  ctrl.cond      = condCode_t'(instr[31:28]);
                  ra1            = instr[19:16];
                  imm            = {20'b0, instr[11:0]};
                  if (!instr[20])
                     ra2 = instr[15:12];          // Store data register
               end
            branch:
               if (instr[25:24] == 2'b10)
               begin
                  ctrl.branch    = 1'b1;
                  ctrl.aluSrcImm = 1'b1;
                  ctrl.cond      = condCode_t'(instr[31:28]);
                  imm            = {{6{instr[23]}}, instr[23:0], 2'b00};
               end
            default: ;
         endcase
      end
   end

endmodule

// ==== logic/regFile.sv ====
// Fifteen general registers, written on the falling clock edge
// so a writeback value is visible to decode in the same cycle
// R15 is not stored and reads as the fetch PC plus 8
`timescale 1ns/1ps

module regFile import armPkg::*;
(
   input  logic     clk,
   input  logic     we,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa,
   input  word_t    wd,
   input  word_t    pcPlus8,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [15];

   always_ff @(negedge clk)
      if (we && wa != r15Reg)
         regs[wa] <= wd;

   assign rd1 = (ra1 == r15Reg) ? pcPlus8 : regs[ra1];
   assign rd2 = (ra2 == r15Reg) ? pcPlus8 : regs[ra2];

endmodule

// ==== logic/condUnit.sv ====
// Condition check against the NZCV register and the flag update
// Flags change one cycle after a passing S instruction executes
// C and V are written as 0 by ANDS/ORRS, since there is no shifter carry
`timescale 1ns/1ps

module condUnit import armPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  condCode_t cond,
   input  logic      setFlags,
   input  flags_t    aluFlags,
   output logic      condEx
);

   flags_t flags;
   logic   ge;

   assign ge = (flags.neg == flags.overflow);

   always_comb
   begin
      case (cond)
         EQ:      condEx = flags.zero;
         NE:      condEx = ~flags.zero;
         CS:      condEx = flags.carry;
         CC:      condEx = ~flags.carry;
         MI:      condEx = flags.neg;
         PL:      condEx = ~flags.neg;
         VS:      condEx = flags.overflow;
         VC:      condEx = ~flags.overflow;
         HI:      condEx = flags.carry & ~flags.zero;
         LS:      condEx = ~flags.carry | flags.zero;
         GE:      condEx = ge;
         LT:      condEx = ~ge;
         GT:      condEx = ~flags.zero & ge;
         LE:      condEx = flags.zero | ~ge;
         AL:      condEx = 1'b1;
         default: condEx = 1'b0;    // NV never reaches here
      endcase
   end

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         flags <= '0;
      else if (setFlags && condEx)
         flags <= aluFlags;         // All four at once
   end

endmodule

// ==== logic/execUnit.sv ====
// Execute stage datapath: operand forwarding, B operand select and ALU
// Forward select 2'b10 takes the memory stage, 2'b01 writeback
// Carry and overflow are only meaningful for ADD and SUB
`timescale 1ns/1ps

module execUnit import armPkg::*;
(
   input  execReg_t   ex,
   input  logic [1:0] forwardA,
   input  logic [1:0] forwardB,
   input  word_t      memResult,
   input  word_t      wbResult,
   output word_t      result,
   output word_t      writeData,
   output flags_t     aluFlags
);

   word_t       srcA;
   word_t       srcB;
   logic        isSub;
   logic        isArith;
   logic [32:0] sum;

   function automatic word_t pickOperand(input logic [1:0] sel, input word_t regVal,
                                         input word_t memVal, input word_t wbVal);
      case (sel)
         2'b10:   return memVal;
         2'b01:   return wbVal;
         default: return regVal;
      endcase
   endfunction

   assign srcA      = pickOperand(forwardA, ex.rd1, memResult, wbResult);
   assign writeData = pickOperand(forwardB, ex.rd2, memResult, wbResult);
   assign srcB      = ex.ctrl.aluSrcImm ? ex.imm : writeData;

   assign isSub   = (ex.ctrl.aluOp == aluSub);
   assign isArith = (ex.ctrl.aluOp == aluAdd) || isSub;
   assign sum     = {1'b0, srcA} + {1'b0, isSub ? ~srcB : srcB} + {32'b0, isSub};

   always_comb
   begin
      case (ex.ctrl.aluOp)
         aluAnd:  result = srcA & srcB;
         aluOrr:  result = srcA | srcB;
         default: result = sum[31:0];   // ADD, SUB, address and target
      endcase
   end

   assign aluFlags.neg  = result[31];
   assign aluFlags.zero = (result == '0);
   assign aluFlags.carry = isArith & sum[32];
   // Operands agree in sign (after inversion for SUB) but the sum does not
   assign aluFlags.overflow = isArith & ~(srcA[31] ^ srcB[31] ^ isSub)
                              & (srcA[31] ^ sum[31]);

endmodule

// ==== logic/hazardUnit.sv ====
// Forwarding selects, load-use stall and branch flush
// Memory stage match wins over writeback; R15 is never a destination
`timescale 1ns/1ps

module hazardUnit import armPkg::*;
(
   input  regAddr_t   ra1D,
   input  regAddr_t   ra2D,
   input  regAddr_t   ra1E,
   input  regAddr_t   ra2E,
   input  regAddr_t   waE,
   input  regAddr_t   waM,
   input  regAddr_t   waW,
   input  logic       regWriteM,
   input  logic       regWriteW,
   input  logic       memToRegE,
   input  logic       branchTaken,
   output logic [1:0] forwardA,
   output logic [1:0] forwardB,
   output logic       stallF,
   output logic       stallD,
   output logic       flushD,
   output logic       flushE
);

   logic loadUse;

   always_comb
   begin
      if (regWriteM && waM == ra1E)
         forwardA = 2'b10;
      else if (regWriteW && waW == ra1E)
         forwardA = 2'b01;
      else
         forwardA = 2'b00;
      if (regWriteM && waM == ra2E)
         forwardB = 2'b10;
      else if (regWriteW && waW == ra2E)
         forwardB = 2'b01;
      else
         forwardB = 2'b00;
   end

   // Load in execute whose result the decode instruction needs
   assign loadUse = memToRegE && (ra1D == waE || ra2D == waE);

   assign stallF = loadUse;
   assign stallD = loadUse;
   assign flushD = branchTaken;            // Drop the wrong-path decode
   assign flushE = loadUse | branchTaken;  // Bubble into execute

endmodule

// ==== logic/armCore.sv ====
// Five-stage pipelined core for a subset of ARMv4
// Instruction and data memories are combinational reads; stores commit
// on the rising edge while memWrite is high
// resetPc must be word-aligned; branches resolve in execute, no prediction
`timescale 1ns/1ps

module armCore import armPkg::*;
#(
   parameter word_t resetPc = '0
)
(
   input  logic  clk,
   input  logic  reset,
   output word_t pc,
   input  word_t instr,
   output word_t dataAddr,
   output word_t writeData,
   output logic  memWrite,
   input  word_t readData
);

   word_t      pcPlus4F, pcNext;
   word_t      instrD;
   logic       validD;
   ctrl_t      ctrlD;
   word_t      immD, rd1D, rd2D;
   regAddr_t   ra1D, ra2D, waD;
   execReg_t   exReg, exNext;
   word_t      resultE, writeDataE;
   flags_t     aluFlagsE;
   logic       condEx, branchTaken;
   memReg_t    memReg, memNext;
   wbReg_t     wbReg, wbNext;
   word_t      resultW;
   logic [1:0] forwardA, forwardB;
   logic       stallF, stallD, flushD, flushE;

   // Fetch
   assign pcPlus4F = pc + 32'd4;
   assign pcNext   = branchTaken ? resultE : pcPlus4F;   // ALU gives the target

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         pc <= resetPc;
      else if (!stallF)
         pc <= pcNext;
   end

   // Decode
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         instrD <= '0;
         validD <= 1'b0;
      end
      else if (flushD)
      begin
         instrD <= '0;
         validD <= 1'b0;
      end
      else if (!stallD)
      begin
         instrD <= instr;
         validD <= 1'b1;
      end
   end

   armDecoder u_armDecoder (
      .instr(instrD), .ctrl(ctrlD), .imm(immD),
      .ra1(ra1D), .ra2(ra2D), .wa(waD)
   );

   // pc already sits one word past the decode instruction
   regFile u_regFile (
      .clk(clk), .we(wbReg.regWrite), .ra1(ra1D), .ra2(ra2D), .wa(wbReg.wa),
      .wd(resultW), .pcPlus8(pcPlus4F), .rd1(rd1D), .rd2(rd2D)
   );

   assign exNext = '{ctrl: validD ? ctrlD : '0, rd1: rd1D, rd2: rd2D, imm: immD,
                     ra1: ra1D, ra2: ra2D, wa: waD};

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         exReg <= '0;
      else
         exReg <= flushE ? '0 : exNext;
   end

   // Execute
   execUnit u_execUnit (
      .ex(exReg), .forwardA(forwardA), .forwardB(forwardB),
      .memResult(memReg.aluResult), .wbResult(resultW),
      .result(resultE), .writeData(writeDataE), .aluFlags(aluFlagsE)
   );

   condUnit u_condUnit (
      .clk(clk), .reset(reset), .cond(exReg.ctrl.cond),
      .setFlags(exReg.ctrl.setFlags), .aluFlags(aluFlagsE), .condEx(condEx)
   );

   assign branchTaken = exReg.ctrl.branch & condEx;
   assign memNext = '{regWrite: exReg.ctrl.regWrite & condEx,
                      memWrite: exReg.ctrl.memWrite & condEx,
                      memToReg: exReg.ctrl.memToReg & condEx,
                      aluResult: resultE, writeData: writeDataE, wa: exReg.wa};

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         memReg <= '0;
      else
         memReg <= memNext;
   end

   // Memory
   assign dataAddr  = memReg.aluResult;
   assign writeData = memReg.writeData;
   assign memWrite  = memReg.memWrite;
   assign wbNext = '{regWrite: memReg.regWrite, memToReg: memReg.memToReg,
                     aluResult: memReg.aluResult, readData: readData, wa: memReg.wa};

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         wbReg <= '0;
      else
         wbReg <= wbNext;
   end

   // Writeback
   assign resultW = wbReg.memToReg ? wbReg.readData : wbReg.aluResult;

   hazardUnit u_hazardUnit (
      .ra1D(ra1D), .ra2D(ra2D), .ra1E(exReg.ra1), .ra2E(exReg.ra2),
      .waE(exReg.wa), .waM(memReg.wa), .waW(wbReg.wa),
      .regWriteM(memReg.regWrite), .regWriteW(wbReg.regWrite),
      .memToRegE(exReg.ctrl.memToReg), .branchTaken(branchTaken),
      .forwardA(forwardA), .forwardB(forwardB),
      .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
   );

endmodule

// ==== tests/armCore_sva.sv ====
// Protocol checks bound into armCore
// Looks at internal stallF and branchTaken through the bind
`timescale 1ns/1ps

module armCoreSva import armPkg::*;
#(
   parameter word_t resetPc = '0
)
(
   input logic  clk,
   input logic  reset,
   input word_t pc,
   input logic  memWrite,
   input logic  stallF,
   input logic  branchTaken
);

   assert property (@(posedge clk) reset |-> !memWrite)
      else $error("memWrite high during reset");
   assert property (@(posedge clk) disable iff (reset) !$isunknown(memWrite))
      else $error("memWrite is unknown");
   assert property (@(posedge clk) pc[1:0] == 2'b00)
      else $error("pc %h not word aligned", pc);
   assert property (@(posedge clk) $fell(reset) |-> pc == resetPc)
      else $error("pc %h after reset, expected %h", pc, resetPc);

   // Next pc is pc plus 4 unless a stall or a taken branch applies
   assert property (@(posedge clk) disable iff (reset)
                    (!stallF && !branchTaken) |=> pc == $past(pc) + 32'd4)
      else $error("pc did not advance by 4");
   // A load-use stall holds pc for a single cycle
   assert property (@(posedge clk) disable iff (reset) stallF |=> !stallF)
      else $error("stall lasted more than one cycle");

endmodule

bind armCore armCoreSva #(.resetPc(resetPc)) u_armCoreSva (.*);

// ==== tests/armCoreTb.sv ====
// Testbench for armCore with a fixed program template and random immediates,
// checked against a sequential model of the same program
// Instruction and data memories are combinational arrays, RAM is 1 KiB
`timescale 1ns/1ps

module armCoreTb import armPkg::*;
();

   localparam int    progLen = 26;
   localparam word_t startPc = 32'h0;

   logic  clk, reset, memWrite;
   word_t pc, instr, dataAddr, writeData, readData, expA, expD, brTgt, tgtHeld;
   word_t imem [64];
   word_t ram [256];
   word_t expRam [256];
   word_t expAddr [16];
   word_t expData [16];
   word_t expTarget [64];
   int    expCount = 0;
   int    storeIdx = 0;
   int    errCount = 0;
   int    segEnd [4] = '{2, 3, 6, 7};

   armCore #(.resetPc(startPc)) u_armCore (
      .clk(clk), .reset(reset), .pc(pc), .instr(instr), .dataAddr(dataAddr),
      .writeData(writeData), .memWrite(memWrite), .readData(readData)
   );

   assign instr    = imem[pc[7:2]];
   assign readData = ram[dataAddr[9:2]];
   assign expA     = expAddr[storeIdx[3:0]];
   assign expD     = expData[storeIdx[3:0]];
   assign brTgt    = expTarget[6'(pc[7:2] - 6'd2)];   // Branch sits two words back

   always @(posedge clk)
      if (memWrite)
      begin
         ram[dataAddr[9:2]] <= writeData;
         storeIdx <= storeIdx + 1;
      end

   always @(posedge clk)
      tgtHeld <= brTgt;         // Target as seen while the branch executes

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic reportError(input string msg);
      $display("%s", msg);
      errCount++;
   endtask

   function automatic word_t dpImm(logic [3:0] c, logic [3:0] op, logic s, regAddr_t rn,
                                   regAddr_t rd, logic [7:0] im);
      return {c, 3'b001, op, s, rn, rd, 4'h0, im};
   endfunction

   function automatic word_t dpReg(logic [3:0] c, logic [3:0] op, logic s, regAddr_t rn,
                                   regAddr_t rd, regAddr_t rm);
      return {c, 3'b000, op, s, rn, rd, 8'h00, rm};
   endfunction

   function automatic word_t ldst(logic [3:0] c, logic ld, regAddr_t rn, regAddr_t rd,
                                  logic [11:0] off);
      return {c, 2'b01, 5'b01100, ld, rn, rd, off};
   endfunction

   function automatic word_t bra(logic [3:0] c, logic [23:0] off);
      return {c, 4'b1010, off};
   endfunction

   function automatic logic condOk(logic [3:0] c, logic n, logic z, logic v);
      case (c)
         4'h0:    return z;
         4'h1:    return !z;
         4'hA:    return n == v;
         4'hB:    return n != v;
         4'hE:    return 1'b1;
         default: return 1'b0;   // Not used by the template
      endcase
   endfunction

   // Sequential architectural model that stops at the branch to itself
   task automatic runModel();
      word_t       r [16];
      word_t       ins, a, b, res, addr;
      logic [32:0] wide;
      logic        n, z, v, done;
      int          w, steps;
      n = 0;
      z = 0;
      v = 0;
      w = 0;
      steps = 0;
      done = 0;
      while (!done && steps < 200)
      begin
         ins   = imem[w];
         r[15] = w * 4 + 8;
         steps++;
         if (!condOk(ins[31:28], n, z, v))
            w++;
         else if (ins[27:26] == 2'b00)
         begin
            a = r[ins[19:16]];
            b = ins[25] ? {24'b0, ins[7:0]} : r[ins[3:0]];
            wide = (ins[24:21] == 4'h2) ? {1'b0, a} + {1'b0, ~b} + 33'd1 : {1'b0, a} + b;
            case (ins[24:21])
               4'h0:    res = a & b;
               4'hC:    res = a | b;
               default: res = wide[31:0];
            endcase
            r[ins[15:12]] = res;
            if (ins[20])
            begin
               n = res[31];
               z = (res == 0);
               if (ins[24:21] == 4'h4)
                  v = (a[31] == b[31]) && (res[31] != a[31]);
               else
                  v = (ins[24:21] == 4'h2) && (a[31] != b[31]) && (res[31] != a[31]);
            end
            w++;
         end
         else if (ins[27:26] == 2'b01)
         begin
            addr = r[ins[19:16]] + ins[11:0];
            if (ins[20])
               r[ins[15:12]] = expRam[addr[9:2]];
            else
            begin
               expRam[addr[9:2]] = r[ins[15:12]];
               expAddr[expCount] = addr;
               expData[expCount] = r[ins[15:12]];
               expCount++;
            end
            w++;
         end
         else
         begin
            res = w * 4 + 8 + 4 * $signed(ins[23:0]);   // Branch address plus 8 plus words
            expTarget[w] = res;
            done = (res == w * 4);
            w = res >> 2;
         end
      end
   endtask

   task automatic buildProgram();
      logic [7:0] i1, i2, i3, i4;
      i1 = 8'($urandom);
      i2 = 8'(1 + $urandom % 255);   // Nonzero so r1 - r2 is negative
      i3 = 8'($urandom);
      i4 = 8'($urandom);
      for (int i = 0; i < 64; i++)
      begin
         imem[i] = 32'hF000_0000 | i;   // NV no-op
         expTarget[i] = '0;
      end
      for (int i = 0; i < 256; i++)
         ram[i] = i * 32'h9E37_79B1;
      ram[32] = $urandom;             // Load word at 0x80
      imem[0]  = dpReg(4'hE, 4'h2, 0, 15, 0, 15);      // r0 = 0
      imem[1]  = dpImm(4'hE, 4'h4, 0, 0, 1, i1);
      imem[2]  = dpImm(4'hE, 4'h4, 0, 1, 2, i2);
      imem[3]  = dpReg(4'hE, 4'h2, 0, 2, 3, 1);
      imem[4]  = dpImm(4'hE, 4'h0, 0, 3, 4, i3);
      imem[5]  = dpReg(4'hE, 4'hC, 0, 1, 5, 4);
      imem[6]  = dpReg(4'hE, 4'h4, 0, 3, 6, 5);
      imem[7]  = ldst(4'hE, 0, 0, 6, 12'h40);
      imem[8]  = ldst(4'hE, 0, 0, 4, 12'h44);
      imem[9]  = ldst(4'hE, 1, 0, 7, 12'h80);
      imem[10] = dpImm(4'hE, 4'h4, 0, 7, 8, i4);
      imem[11] = ldst(4'hE, 0, 0, 8, 12'h48);
      imem[12] = dpReg(4'hE, 4'h2, 1, 1, 9, 1);        // SUBS to zero
      imem[13] = dpImm(4'h0, 4'h4, 0, 8, 10, 8'd1);
      imem[14] = ldst(4'h0, 0, 0, 10, 12'h4C);
      imem[15] = ldst(4'h1, 0, 0, 10, 12'h50);
      imem[16] = dpReg(4'hE, 4'h2, 1, 1, 9, 2);        // SUBS negative
      imem[17] = ldst(4'hA, 0, 0, 1, 12'h54);
      imem[18] = ldst(4'hB, 0, 0, 2, 12'h58);
      imem[19] = ldst(4'h1, 0, 0, 3, 12'h5C);
      imem[20] = bra(4'hE, 24'd1);                     // Skips 21 and 22
      imem[21] = ldst(4'hE, 0, 0, 1, 12'h60);
      imem[22] = ldst(4'hE, 0, 0, 2, 12'h64);
      imem[23] = bra(4'h0, 24'd5);                     // Not taken
      imem[24] = ldst(4'hE, 0, 0, 5, 12'h68);
      imem[25] = bra(4'hE, 24'hFF_FFFE);               // Branch to itself
      expRam = ram;
   endtask

   assert property (@(posedge clk) (reset || $fell(reset)) |-> pc == startPc)
      else reportError($sformatf("ERROR pc got %h expected %h in reset", $sampled(pc),
                                 startPc));
   assert property (@(posedge clk) (reset || $fell(reset)) |-> !memWrite)
      else reportError($sformatf("ERROR memWrite got %h expected 0 in reset",
                                 $sampled(memWrite)));
   assert property (@(posedge clk) disable iff (reset) memWrite |-> storeIdx < expCount)
      else reportError($sformatf("Unexpected store at address %h", $sampled(dataAddr)));
   assert property (@(posedge clk) disable iff (reset)
                    (memWrite && storeIdx < expCount) |-> dataAddr == expA)
      else reportError($sformatf("ERROR dataAddr got %h expected %h", $sampled(dataAddr),
                                 $sampled(expA)));
   assert property (@(posedge clk) disable iff (reset)
                    (memWrite && storeIdx < expCount) |-> writeData == expD)
      else reportError($sformatf("ERROR writeData got %h expected %h", $sampled(writeData),
                                 $sampled(expD)));
   assert property (@(posedge clk) disable iff (reset)
                    u_armCore.branchTaken |=> pc == tgtHeld)
      else reportError($sformatf("ERROR pc got %h expected %h after branch", $sampled(pc),
                                 $sampled(tgtHeld)));

   // Watchdog sized from the program length
   initial
   begin
      #((progLen + 20) * 4 * 100);
      $display("Timeout: stores did not complete in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      string names [4] = '{"dependent ALU", "load-use", "conditional", "branch"};
      reset = 1'b1;
      void'($urandom(32'h29c3));
      buildProgram();
      runModel();
      repeat (10) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      $display("Test reset finished, errors so far %0d", errCount);
      for (int s = 0; s < 4; s++)
      begin
         wait (storeIdx >= segEnd[s]);
         @(negedge clk);
         $display("Test %s finished, errors so far %0d", names[s], errCount);
      end
      repeat (12) @(negedge clk);                  // Let any stray store show
      assert (storeIdx == expCount)
         else reportError($sformatf("Store count %0d differs from %0d", storeIdx, expCount));
      for (int i = 0; i < 256; i++)
         assert (ram[i] == expRam[i])
            else reportError($sformatf("ERROR ram[%0d] got %h expected %h", i, ram[i],
                                       expRam[i]));
      $display("Tests: 5, stores: %0d, errors: %0d", storeIdx, errCount);
      if (errCount == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== all.f ====
logic/armPkg.sv
logic/armDecoder.sv
logic/regFile.sv
logic/condUnit.sv
logic/execUnit.sv
logic/hazardUnit.sv
logic/armCore.sv
tests/armCore_sva.sv
tests/armCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module armCoreTb \
   -f all.f -o armCoreSim > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/armCoreSim > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log && echo "PASS" \
   || { echo "FAIL, see sim.log"; exit 1; }
